// ==== src.f ====
hw/lsu_pkg.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/lsu_top.sv
sim/data_sram_model.sv
sim/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_lsu -f src.f -o tb_lsu \
    && ./obj_dir/tb_lsu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== sim/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

    localparam int num_ops         = 400;
    localparam int watchdog_cycles = num_ops * 40;

    typedef struct packed {
        logic [op_w-1:0]       op;
        logic [data_w-1:0]     addr;
        logic [data_w-1:0]     data;
        logic [reg_addr_w-1:0] waddr;
        logic [data_w-1:0]     pc;
    } exp_t;

    logic                  clk;
    logic                  resetn;
    logic                  in_valid;
    logic                  in_ready;
    logic [op_w-1:0]       in_op;
    logic [data_w-1:0]     in_base;
    logic [data_w-1:0]     in_offset;
    logic [data_w-1:0]     in_st_data;
    logic [reg_addr_w-1:0] in_waddr;
    logic [data_w-1:0]     in_pc;
    logic                  data_req;
    logic                  data_wr;
    logic [3:0]            data_wstrb;
    logic [data_w-1:0]     data_addr;
    logic [data_w-1:0]     data_wdata;
    logic                  data_addr_ok;
    logic [data_w-1:0]     data_rdata;
    logic                  data_data_ok;
    logic                  retire_valid;
    logic                  retire_we;
    logic [reg_addr_w-1:0] retire_waddr;
    logic [data_w-1:0]     retire_wdata;
    logic [data_w-1:0]     retire_pc;
    logic                  retire_ex;

    logic [data_w-1:0]     model_mem [256];
    exp_t                  exp_q [$];
    logic [data_w:0]       req_q [$];
    logic [data_w-1:0]     pc_next;
    integer                seed;
    int                    errors;
    int                    retired;
    int                    flushed;
    int                    n_sent;
    int                    i;

    lsu_top UUT (.*);

    data_sram_model u_sram (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg_addr(input string name, input logic [reg_addr_w-1:0] got,
                                  input logic [reg_addr_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic misaligned(input logic [op_w-1:0] op, input logic [data_w-1:0] addr);
        if (op inside {op_ld_h, op_ld_hu, op_st_h}) return addr[0];
        if (op inside {op_ld_w, op_st_w}) return addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    function automatic logic is_store(input logic [op_w-1:0] op);
        return op inside {op_st_b, op_st_h, op_st_w};
    endfunction

    // the field is picked by the low address bits, then extended by op
    function automatic logic [data_w-1:0] load_value(input exp_t e);
        rdata_u w;
        w = model_mem[e.addr[9:2]];
        case (e.op)
            op_ld_b:  return {{24{w.bytes[e.addr[1:0]][7]}}, w.bytes[e.addr[1:0]]};
            op_ld_bu: return {24'h0, w.bytes[e.addr[1:0]]};
            op_ld_h:  return {{16{w.halves[e.addr[1]][15]}}, w.halves[e.addr[1]]};
            op_ld_hu: return {16'h0, w.halves[e.addr[1]]};
            default:  return w;
        endcase
    endfunction

    task automatic store_model(input exp_t e);
        rdata_u w;
        w = model_mem[e.addr[9:2]];
        case (e.op)
            op_st_b: w.bytes[e.addr[1:0]] = e.data[7:0];
            op_st_h: w.halves[e.addr[1]] = e.data[15:0];
            default: w = e.data;
        endcase
        model_mem[e.addr[9:2]] = w;
    endtask

    task automatic check_retire();
        exp_t            e;
        logic [data_w:0] r;
        logic            fault;
        if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected retire of pc %h with no op outstanding", retire_pc);
            return;
        end
        e = exp_q.pop_front();
        fault = misaligned(e.op, e.addr);
        retired++;
        check_word("retire_pc", retire_pc, e.pc);
        check_reg_addr("retire_waddr", retire_waddr, e.waddr);
        check_flag("retire_ex", retire_ex, fault);
        check_flag("retire_we", retire_we, !fault && !is_store(e.op));
        if (fault) begin
            // all younger ops left in the queue were accepted before this retire
            flushed += exp_q.size();
            exp_q.delete();
        end else if (e.op != op_alu) begin
            if (req_q.size() == 0) begin
                errors++;
                $display("memory op at pc %h retired without an SRAM request", e.pc);
            end else begin
                r = req_q.pop_front();
                check_word("data_addr", r[data_w-1:0], e.addr);
                check_flag("data_wr", r[data_w], is_store(e.op));
            end
            if (is_store(e.op)) begin
                store_model(e);
            end else begin
                check_word("retire_wdata", retire_wdata, load_value(e));
            end
        end else begin
            check_word("retire_wdata", retire_wdata, e.data);
        end
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            if (data_req && data_addr_ok) begin
                req_q.push_back({data_wr, data_addr});
            end
            if (retire_valid) begin
                check_retire();
            end
            if (in_valid && in_ready) begin
                exp_q.push_back({in_op, in_base + in_offset, in_st_data, in_waddr, in_pc});
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_op();
        logic [data_w-1:0] rnd;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] offset;
        logic [op_w-1:0]   op;
        rnd = $random(seed);
        case (rnd[3:0])
            4'd0, 4'd1, 4'd2: op = op_alu;
            4'd3:             op = op_ld_b;
            4'd4:             op = op_ld_bu;
            4'd5, 4'd6:       op = op_ld_h;
            4'd7:             op = op_ld_hu;
            4'd8, 4'd9:       op = op_ld_w;
            4'd10, 4'd11:     op = op_st_b;
            4'd12:            op = op_st_h;
            default:          op = op_st_w;
        endcase
        // the addresses span sixteen words so loads often land on recently stored data
        addr = 32'h0000_0200 + {26'd0, rnd[9:4]};
        // about one access in eight keeps its random low bits and may fault
        if (rnd[12:10] != 3'd0) begin
            if (op inside {op_ld_h, op_ld_hu, op_st_h}) addr[0] = 1'b0;
            if (op inside {op_ld_w, op_st_w}) addr[1:0] = 2'b00;
        end
        offset = rnd[13] ? $random(seed) : {24'd0, rnd[21:14]};
        in_valid   <= 1'b1;
        in_op      <= op;
        in_offset  <= offset;
        in_base    <= addr - offset;
        in_st_data <= $random(seed);
        in_waddr   <= rnd[26:22];
        in_pc      <= pc_next;
        pc_next = pc_next + 32'd4;
    endtask

    initial begin
        seed = 32'h171760d0;
        pc_next = 32'h0000_1000;
        resetn     <= 1'b0;
        in_valid   <= 1'b0;
        in_op      <= op_alu;
        in_base    <= '0;
        in_offset  <= '0;
        in_st_data <= '0;
        in_waddr   <= '0;
        in_pc      <= '0;
        repeat (5) @(posedge clk);
        for (i = 0; i < 256; i++) begin
            model_mem[i] = u_sram.mem[i];
        end
        resetn <= 1'b1;
        while (n_sent < num_ops) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                n_sent++;
            end
            if (!in_valid || in_ready) begin
                if (n_sent < num_ops && ($random(seed) & 3) != 0) begin
                    drive_op();
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        if (req_q.size() != 0) begin
            errors++;
            $display("%0d SRAM requests were never matched by a retiring memory op",
                     req_q.size());
        end
        // the stored bytes that no later load read back are still compared here
        for (i = 0; i < 256; i++) begin
            check_word($sformatf("sram mem[%0d]", i), u_sram.mem[i], model_mem[i]);
        end
        $display("errors %0d, retired %0d, flushed %0d", errors, retired, flushed);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d ops outstanding",
                 watchdog_cycles, exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sim/data_sram_model.sv ====
`timescale 1ns/1ps

module data_sram_model import lsu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              data_req,
    input  logic              data_wr,
    input  logic [3:0]        data_wstrb,
    input  logic [data_w-1:0] data_addr,
    input  logic [data_w-1:0] data_wdata,
    output logic              data_addr_ok,
    output logic [data_w-1:0] data_rdata,
    output logic              data_data_ok
);

    logic [data_w-1:0] mem [256];
    logic [data_w-1:0] resp_data [$];
    int                resp_due [$];
    logic [1:0]        addr_delay;
    logic [1:0]        addr_wait;
    logic [31:0]       rnd;
    logic [7:0]        idx;
    integer            seed;
    int                cycle;
    int                due;
    int                i;
    int                b;

    // every word starts with a value that depends on its whole index
    initial begin
        seed = 32'h171760d0;
        addr_wait    <= 2'd0;
        addr_delay   <= 2'd0;
        data_data_ok <= 1'b0;
        data_rdata   <= '0;
        for (i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], 8'hc3 - i[7:0], i[7:0]};
        end
    end

    // addr_ok follows after 0 to 3 cycles of data_req
    assign data_addr_ok = data_req && (addr_wait >= addr_delay);

    always @(posedge clk) begin
        if (!resetn) begin
            addr_wait    <= 2'd0;
            addr_delay   <= 2'd0;
            data_data_ok <= 1'b0;
            data_rdata   <= '0;
            resp_data.delete();
            resp_due.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            rnd = $random(seed);
            if (data_req && data_addr_ok) begin
                idx = data_addr[9:2];
                for (b = 0; b < 4; b++) begin
                    if (data_wr && data_wstrb[b]) begin
                        mem[idx][8*b +: 8] = data_wdata[8*b +: 8];
                    end
                end
                // responses stay in order, so a short delay waits behind a long one
                due = cycle + int'(rnd[3:2]);
                if (resp_due.size() > 0 && due <= resp_due[$]) begin
                    due = resp_due[$] + 1;
                end
                resp_data.push_back(mem[idx]);
                resp_due.push_back(due);
                addr_wait  <= 2'd0;
                addr_delay <= rnd[1:0];
            end else if (data_req && addr_wait != 2'd3) begin
                addr_wait <= addr_wait + 2'd1;
            end
            if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
                data_data_ok <= 1'b1;
                data_rdata   <= resp_data.pop_front();
                void'(resp_due.pop_front());
            end else begin
                data_data_ok <= 1'b0;
                // idle read data is noise so that stale words show up as errors
                data_rdata   <= rnd;
            end
        end
    end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // issue port
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [op_w-1:0]       in_op,
    input  logic [data_w-1:0]     in_base,
    input  logic [data_w-1:0]     in_offset,
    input  logic [data_w-1:0]     in_st_data,
    input  logic [reg_addr_w-1:0] in_waddr,
    input  logic [data_w-1:0]     in_pc,
    // data sram
    output logic                  data_req,
    output logic                  data_wr,
    output logic [3:0]            data_wstrb,
    output logic [data_w-1:0]     data_addr,
    output logic [data_w-1:0]     data_wdata,
    input  logic                  data_addr_ok,
    input  logic [data_w-1:0]     data_rdata,
    input  logic                  data_data_ok,
    // retire port
    output logic                  retire_valid,
    output logic                  retire_we,
    output logic [reg_addr_w-1:0] retire_waddr,
    output logic [data_w-1:0]     retire_wdata,
    output logic [data_w-1:0]     retire_pc,
    output logic                  retire_ex
);

    // ex to mem
    logic                  es_to_ms_valid;
    logic [op_w-1:0]       es_op;
    logic [data_w-1:0]     es_addr;
    logic [reg_addr_w-1:0] es_waddr;
    logic [data_w-1:0]     es_pc;
    logic                  es_ale;
    logic                  es_wait_resp;
    logic                  ms_allowin;
    logic                  ms_ex;

    // mem to wb
    logic                  ms_to_ws_valid;
    logic                  ms_rf_we;
    logic [reg_addr_w-1:0] ms_waddr;
    logic [data_w-1:0]     ms_wdata;
    logic [data_w-1:0]     ms_pc;
    logic                  ms_ale;
    logic                  ws_allowin;
    logic                  wb_ex;

    ex_stage u_ex (
        .clk            (clk),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_op          (in_op),
        .in_base        (in_base),
        .in_offset      (in_offset),
        .in_st_data     (in_st_data),
        .in_waddr       (in_waddr),
        .in_pc          (in_pc),
        .ms_allowin     (ms_allowin),
        .ms_ex          (ms_ex),
        .wb_ex          (wb_ex),
        .es_to_ms_valid (es_to_ms_valid),
        .es_op          (es_op),
        .es_addr        (es_addr),
        .es_waddr       (es_waddr),
        .es_pc          (es_pc),
        .es_ale         (es_ale),
        .es_wait_resp   (es_wait_resp),
        .data_req       (data_req),
        .data_wr        (data_wr),
        .data_wstrb     (data_wstrb),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_addr_ok   (data_addr_ok)
    );

    mem_stage u_mem (
        .clk            (clk),
        .resetn         (resetn),
        .wb_ex          (wb_ex),
        .es_to_ms_valid (es_to_ms_valid),
        .es_op          (es_op),
        .es_addr        (es_addr),
        .es_waddr       (es_waddr),
        .es_pc          (es_pc),
        .es_ale         (es_ale),
        .es_wait_resp   (es_wait_resp),
        .ms_allowin     (ms_allowin),
        .ms_ex          (ms_ex),
        .data_rdata     (data_rdata),
        .data_data_ok   (data_data_ok),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_rf_we       (ms_rf_we),
        .ms_waddr       (ms_waddr),
        .ms_wdata       (ms_wdata),
        .ms_pc          (ms_pc),
        .ms_ale         (ms_ale)
    );

    wb_stage u_wb (
        .clk            (clk),
        .resetn         (resetn),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_rf_we       (ms_rf_we),
        .ms_waddr       (ms_waddr),
        .ms_wdata       (ms_wdata),
        .ms_pc          (ms_pc),
        .ms_ale         (ms_ale),
        .ws_allowin     (ws_allowin),
        .wb_ex          (wb_ex),
        .retire_valid   (retire_valid),
        .retire_we      (retire_we),
        .retire_waddr   (retire_waddr),
        .retire_wdata   (retire_wdata),
        .retire_pc      (retire_pc),
        .retire_ex      (retire_ex)
    );

endmodule

// ==== hw/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // from mem
    input  logic                  ms_to_ws_valid,
    input  logic                  ms_rf_we,
    input  logic [reg_addr_w-1:0] ms_waddr,
    input  logic [data_w-1:0]     ms_wdata,
    input  logic [data_w-1:0]     ms_pc,
    input  logic                  ms_ale,
    output logic                  ws_allowin,
    output logic                  wb_ex,
    // retire port
    output logic                  retire_valid,
    output logic                  retire_we,
    output logic [reg_addr_w-1:0] retire_waddr,
    output logic [data_w-1:0]     retire_wdata,
    output logic [data_w-1:0]     retire_pc,
    output logic                  retire_ex
);

    logic ws_valid;
    logic ws_rf_we;
    logic ws_ale;

    // the retire port never stalls, so wb finishes every op in one cycle
    assign ws_allowin = 1'b1;

    // an op arriving on the flush edge is younger than the fault and is dropped
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid && !wb_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_rf_we     <= ms_rf_we;
            retire_waddr <= ms_waddr;
            retire_wdata <= ms_wdata;
            retire_pc    <= ms_pc;
            ws_ale       <= ms_ale;
        end
    end

    assign wb_ex        = ws_valid && ws_ale;
    assign retire_valid = ws_valid;
    assign retire_ex    = wb_ex;
    assign retire_we    = ws_valid && ws_rf_we && !ws_ale;

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  wb_ex,
    // from ex
    input  logic                  es_to_ms_valid,
    input  logic [op_w-1:0]       es_op,
    input  logic [data_w-1:0]     es_addr,
    input  logic [reg_addr_w-1:0] es_waddr,
    input  logic [data_w-1:0]     es_pc,
    input  logic                  es_ale,
    input  logic                  es_wait_resp,
    output logic                  ms_allowin,
    output logic                  ms_ex,
    // data sram response side
    input  logic [data_w-1:0]     data_rdata,
    input  logic                  data_data_ok,
    // to wb
    input  logic                  ws_allowin,
    output logic                  ms_to_ws_valid,
    output logic                  ms_rf_we,
    output logic [reg_addr_w-1:0] ms_waddr,
    output logic [data_w-1:0]     ms_wdata,
    output logic [data_w-1:0]     ms_pc,
    output logic                  ms_ale
);

    logic              ms_valid;
    logic              ms_ready_go;
    logic [op_w-1:0]   ms_op;
    logic [data_w-1:0] ms_addr;
    logic              ms_wait_resp;
    logic              ms_buf_valid;
    logic [data_w-1:0] ms_buf;
    logic              ms_is_ld;
    rdata_u            ms_word;
    logic [15:0]       ms_half;
    logic [7:0]        ms_byte;
    logic [data_w-1:0] ms_load;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // ops without an accepted request are done one cycle after entry
    assign ms_ready_go    = !ms_wait_resp || data_data_ok || ms_buf_valid;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;
    assign ms_ex          = ms_valid && ms_ale;

    always_ff @(posedge clk) begin
        if (!resetn || wb_ex) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_op        <= es_op;
            ms_addr      <= es_addr;
            ms_waddr     <= es_waddr;
            ms_pc        <= es_pc;
            ms_ale       <= es_ale;
            ms_wait_resp <= es_wait_resp;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data_ok is a single pulse, so it is kept here until wb takes the op
    always_ff @(posedge clk) begin
        if (!resetn || wb_ex) begin
            ms_buf_valid <= 1'b0;
        end else if (ms_to_ws_valid && ws_allowin) begin
            ms_buf_valid <= 1'b0;
        end else if (ms_valid && ms_wait_resp && data_data_ok && !ms_buf_valid) begin
            ms_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_data_ok && !ms_buf_valid) begin
            ms_buf <= data_rdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load alignment and extension
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ms_word = ms_buf_valid ? ms_buf : data_rdata;
    assign ms_half = ms_word.halves[ms_addr[1]];
    assign ms_byte = ms_word.bytes[ms_addr[1:0]];

    always_comb begin
        case (ms_op)
            op_ld_b:  ms_load = {{(data_w - 8){ms_byte[7]}}, ms_byte};
            op_ld_bu: ms_load = {{(data_w - 8){1'b0}}, ms_byte};
            op_ld_h:  ms_load = {{(data_w - 16){ms_half[15]}}, ms_half};
            op_ld_hu: ms_load = {{(data_w - 16){1'b0}}, ms_half};
            op_ld_w:  ms_load = ms_word;
            default:  ms_load = ms_addr;
        endcase
    end

    assign ms_is_ld = ms_op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    assign ms_rf_we = (ms_is_ld || (ms_op == op_alu)) && !ms_ale;
    assign ms_wdata = ms_is_ld ? ms_load : ms_addr;

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // issue port
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [op_w-1:0]       in_op,
    input  logic [data_w-1:0]     in_base,
    input  logic [data_w-1:0]     in_offset,
    input  logic [data_w-1:0]     in_st_data,
    input  logic [reg_addr_w-1:0] in_waddr,
    input  logic [data_w-1:0]     in_pc,
    // state of the older stages
    input  logic                  ms_allowin,
    input  logic                  ms_ex,
    input  logic                  wb_ex,
    // forward to mem
    output logic                  es_to_ms_valid,
    output logic [op_w-1:0]       es_op,
    output logic [data_w-1:0]     es_addr,
    output logic [reg_addr_w-1:0] es_waddr,
    output logic [data_w-1:0]     es_pc,
    output logic                  es_ale,
    output logic                  es_wait_resp,
    // data sram request side
    output logic                  data_req,
    output logic                  data_wr,
    output logic [3:0]            data_wstrb,
    output logic [data_w-1:0]     data_addr,
    output logic [data_w-1:0]     data_wdata,
    input  logic                  data_addr_ok
);

    logic              es_valid;
    logic              es_ready_go;
    logic              es_allowin;
    logic              es_req_done;
    logic              es_addr_hs;
    logic [data_w-1:0] es_vaddr;
    logic [data_w-1:0] es_st_data;
    logic              es_is_mem;
    logic              es_is_st;
    logic              es_is_half;
    logic              es_is_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a memory op leaves in the cycle its address is taken by the sram
    assign es_ready_go    = !es_is_mem || es_ale || es_addr_hs || es_req_done;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign in_ready       = es_allowin && !wb_ex;

    always_ff @(posedge clk) begin
        if (!resetn || wb_ex) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            es_op      <= in_op;
            es_vaddr   <= in_base + in_offset;
            es_st_data <= in_st_data;
            es_waddr   <= in_waddr;
            es_pc      <= in_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_req_done <= 1'b0;
        end else if (in_valid && in_ready) begin
            es_req_done <= 1'b0;
        end else if (es_addr_hs) begin
            es_req_done <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address check and request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign es_is_mem  = (es_op != op_alu);
    assign es_is_st   = (es_op == op_st_b) || (es_op == op_st_h) || (es_op == op_st_w);
    assign es_is_half = (es_op == op_ld_h) || (es_op == op_ld_hu) || (es_op == op_st_h);
    assign es_is_word = (es_op == op_ld_w) || (es_op == op_st_w);

    assign es_ale = (es_is_half && es_vaddr[0]) || (es_is_word && (es_vaddr[1:0] != 2'b00));

    // an older fault in mem or wb will flush this op, so its request is held back
    assign data_req = es_valid && es_is_mem && !es_ale && !es_req_done && ms_allowin
                      && !ms_ex && !wb_ex;
    assign es_addr_hs   = data_req && data_addr_ok;
    assign es_wait_resp = es_addr_hs || es_req_done;

    // alu ops reuse the address field to carry their result
    assign es_addr    = (es_op == op_alu) ? es_st_data : es_vaddr;
    assign data_addr  = es_vaddr;
    assign data_wr    = es_is_st;
    assign data_wdata = es_st_data << {es_vaddr[1:0], 3'b000};

    always_comb begin
        case (es_op)
            op_st_b: data_wstrb = 4'b0001 << es_vaddr[1:0];
            op_st_h: data_wstrb = es_vaddr[1] ? 4'b1100 : 4'b0011;
            op_st_w: data_wstrb = 4'b1111;
            default: data_wstrb = 4'b0000;
        endcase
    end

endmodule

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data words, addresses and pc all share the machine word width
    localparam int data_w     = 32;
    localparam int op_w       = 4;
    localparam int reg_addr_w = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // op_alu carries a finished result through the memory stages
    localparam logic [op_w-1:0] op_alu   = 4'd0;

    localparam logic [op_w-1:0] op_ld_b  = 4'd1;
    localparam logic [op_w-1:0] op_ld_bu = 4'd2;
    localparam logic [op_w-1:0] op_ld_h  = 4'd3;
    localparam logic [op_w-1:0] op_ld_hu = 4'd4;
    localparam logic [op_w-1:0] op_ld_w  = 4'd5;

    localparam logic [op_w-1:0] op_st_b  = 4'd6;
    localparam logic [op_w-1:0] op_st_h  = 4'd7;
    localparam logic [op_w-1:0] op_st_w  = 4'd8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read data views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one sram word, indexed by address bit 1 as halves or bits 1:0 as bytes
    typedef union packed {
        logic [1:0][15:0] halves;
        logic [3:0][7:0]  bytes;
    } rdata_u;

endpackage
